//--- logic/elem_pkg.sv
// shared types, constants and host register map for the pulse element bank; import into each block
`default_nettype none

package elem_pkg;

	localparam int NELEM = 4;

	// host register address layout, {elem[1:0], 2'b00, field[3:0]}
	localparam int REG_FIELD_W = 4;
	localparam int REG_ELEM_LSB = 6;

	typedef logic signed [15:0] sample_t;  // one I or Q component
	typedef logic [9:0] taddr_t;           // table address
	typedef logic [15:0] amp_t;            // 32768 is unity gain
	typedef logic [7:0] reg_addr_t;
	typedef logic [31:0] reg_data_t;

	// constant envelope used in continuous-wave mode
	localparam sample_t FULL_SCALE = 16'sd32767;

	typedef enum logic [3:0] {
		ENVSTART = 4'h0,
		ENVLEN   = 4'h1,
		FREQADDR = 4'h2,
		AMP      = 4'h3,
		GO       = 4'h4,
		STOP     = 4'h5
	} reg_field_e;

	typedef enum logic {
		ENV = 1'b0,
		LO  = 1'b1
	} tbl_sel_e;

endpackage

`default_nettype wire

//--- logic/elem_cmd_if.sv
// per-element pulse settings and start/stop strobes, driven by elem_regs and read by elem_conn
`timescale 1ns/1ps
`default_nettype none

interface elem_cmd_if ();
	import elem_pkg::*;

	taddr_t envstart;
	taddr_t envlength;  // zero selects continuous wave
	taddr_t freqaddr;
	amp_t amp;
	logic start;        // single-cycle, no acknowledge
	logic stop;

	modport cfg (
		output envstart,
		output envlength,
		output freqaddr,
		output amp,
		output start,
		output stop
	);

	modport seq (
		input envstart,
		input envlength,
		input freqaddr,
		input amp,
		input start,
		input stop
	);

endinterface

`default_nettype wire

//--- logic/am_mod.sv
// envelope times carrier, then amplitude scaling; two register stages from input to output
`timescale 1ns/1ps
`default_nettype none

module am_mod (
	input  logic              elem,
	input  logic              rst_n,
	input  logic              in_valid,
	input  elem_pkg::sample_t env_i,
	input  elem_pkg::sample_t env_q,
	input  elem_pkg::sample_t lo_i,
	input  elem_pkg::sample_t lo_q,
	input  elem_pkg::amp_t    amp,
	output logic              out_valid,
	output elem_pkg::sample_t out_i,
	output elem_pkg::sample_t out_q
);
	import elem_pkg::*;

	logic signed [31:0] ex_c;
	logic signed [31:0] ey_s;
	logic signed [31:0] ex_s;
	logic signed [31:0] ey_c;
	logic signed [32:0] mix_i;
	logic signed [32:0] mix_q;
	sample_t p_i;
	sample_t p_q;
	amp_t amp_r;
	logic valid_r;
	logic signed [16:0] amp_s;
	logic signed [32:0] scl_i;
	logic signed [32:0] scl_q;

	// (ex + j ey)(c + j s)
	assign ex_c = env_i * lo_i;
	assign ey_s = env_q * lo_q;
	assign ex_s = env_i * lo_q;
	assign ey_c = env_q * lo_i;
	assign mix_i = ex_c - ey_s;
	assign mix_q = ex_s + ey_c;

	always_ff @(posedge elem) begin
		p_i <= sample_t'(mix_i >>> 15);  // truncated to 16 bits
		p_q <= sample_t'(mix_q >>> 15);
		amp_r <= amp;
	end

	assign amp_s = signed'({1'b0, amp_r});  // amp is unsigned
	assign scl_i = p_i * amp_s;
	assign scl_q = p_q * amp_s;

	always_ff @(posedge elem) begin
		out_i <= sample_t'(scl_i >>> 15);
		out_q <= sample_t'(scl_q >>> 15);
	end

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			valid_r <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			valid_r <= in_valid;
			out_valid <= valid_r;
		end
	end

endmodule

`default_nettype wire

//--- logic/wave_table.sv
// I/Q sample table with one host write port and a registered read port per element
`timescale 1ns/1ps
`default_nettype none

module wave_table #(
	parameter int TABLE_DEPTH = 1024
) (
	input  logic              elem,
	input  logic              wr_en,
	input  elem_pkg::taddr_t  wr_addr,
	input  elem_pkg::sample_t wr_i,
	input  elem_pkg::sample_t wr_q,
	input  elem_pkg::taddr_t  rd_addr [elem_pkg::NELEM],
	output elem_pkg::sample_t rd_i [elem_pkg::NELEM],
	output elem_pkg::sample_t rd_q [elem_pkg::NELEM]
);
	import elem_pkg::*;

	sample_t mem_i [TABLE_DEPTH];
	sample_t mem_q [TABLE_DEPTH];

	always_ff @(posedge elem) begin
		if (wr_en) begin
			mem_i[wr_addr] <= wr_i;
			mem_q[wr_addr] <= wr_q;
		end
	end

	// data is back one cycle after the address
	always_ff @(posedge elem) begin
		for (int k = 0; k < NELEM; k++) begin
			rd_i[k] <= mem_i[rd_addr[k]];
			rd_q[k] <= mem_q[rd_addr[k]];
		end
	end

endmodule

`default_nettype wire

//--- logic/elem_regs.sv
// register block for one element; decodes host writes into settings and go/stop strobes
`timescale 1ns/1ps
`default_nettype none

module elem_regs #(
	parameter int unsigned ELEM_ID = 0
) (
	input  logic                elem,
	input  logic                rst_n,
	input  logic                wr_en,
	input  elem_pkg::reg_addr_t wr_addr,
	input  elem_pkg::reg_data_t wr_data,
	elem_cmd_if.cfg             cmd
);
	import elem_pkg::*;

	logic hit;
	reg_field_e field;

	// element select on the top bits, the gap bits must be clear
	assign hit = wr_en
		&& (wr_addr[7:REG_ELEM_LSB] == (8 - REG_ELEM_LSB)'(ELEM_ID))
		&& (wr_addr[REG_ELEM_LSB-1:REG_FIELD_W] == '0);
	assign field = reg_field_e'(wr_addr[REG_FIELD_W-1:0]);

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			cmd.envstart <= '0;
			cmd.envlength <= '0;
			cmd.freqaddr <= '0;
			cmd.amp <= '0;
			cmd.start <= 1'b0;
			cmd.stop <= 1'b0;
		end else begin
			cmd.start <= hit && (field == GO);  // pulse, not stored
			cmd.stop <= hit && (field == STOP);
			if (hit) begin
				case (field)
					ENVSTART: cmd.envstart <= taddr_t'(wr_data);
					ENVLEN:   cmd.envlength <= taddr_t'(wr_data);
					FREQADDR: cmd.freqaddr <= taddr_t'(wr_data);
					AMP:      cmd.amp <= amp_t'(wr_data);
					default: ;  // go, stop and unmapped codes
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/elem_conn.sv
// element sequencer; walks envelope and LO addresses for one pulse and feeds the modulator
`timescale 1ns/1ps
`default_nettype none

module elem_conn #(
	parameter int TABLE_DEPTH = 1024
) (
	input  logic              elem,
	input  logic              rst_n,
	elem_cmd_if.seq           cmd,
	output elem_pkg::taddr_t  env_addr,
	output elem_pkg::taddr_t  lo_addr,
	input  elem_pkg::sample_t env_i,
	input  elem_pkg::sample_t env_q,
	input  elem_pkg::sample_t lo_i,
	input  elem_pkg::sample_t lo_q,
	output logic              valid,
	output elem_pkg::sample_t out_i,
	output elem_pkg::sample_t out_q
);
	import elem_pkg::*;

	taddr_t env_ptr;
	taddr_t lo_ptr;
	taddr_t remain;  // samples left, unused in cw mode
	amp_t amp_run;
	amp_t amp_d;
	logic cw_run;
	logic cw_d;
	logic busy;
	logic busy_d;
	sample_t mod_env_i;
	sample_t mod_env_q;

	function automatic taddr_t next_addr(taddr_t a);
		return (a == taddr_t'(TABLE_DEPTH - 1)) ? '0 : a + 1'b1;
	endfunction

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			env_ptr <= '0;
			lo_ptr <= '0;
			remain <= '0;
			amp_run <= '0;
			cw_run <= 1'b0;
			busy <= 1'b0;
		end else if (cmd.start) begin  // also restarts a running pulse
			env_ptr <= cmd.envstart;
			lo_ptr <= cmd.freqaddr;
			remain <= cmd.envlength;
			amp_run <= cmd.amp;
			cw_run <= (cmd.envlength == '0);
			busy <= 1'b1;
		end else if (busy) begin
			env_ptr <= next_addr(env_ptr);
			lo_ptr <= next_addr(lo_ptr);
			if (cw_run) begin
				if (cmd.stop)
					busy <= 1'b0;
			end else begin
				remain <= remain - 1'b1;
				if (remain == taddr_t'(1))
					busy <= 1'b0;  // last sample issued this cycle
			end
		end
	end

	// line up with the table data, one cycle behind the address
	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			busy_d <= 1'b0;
			cw_d <= 1'b0;
			amp_d <= '0;
		end else begin
			busy_d <= busy;
			cw_d <= cw_run;
			amp_d <= amp_run;
		end
	end

	assign env_addr = env_ptr;
	assign lo_addr = lo_ptr;

	assign mod_env_i = cw_d ? FULL_SCALE : env_i;
	assign mod_env_q = cw_d ? sample_t'(0) : env_q;

	am_mod am_mod_i (
		.elem      (elem),
		.rst_n     (rst_n),
		.in_valid  (busy_d),
		.env_i     (mod_env_i),
		.env_q     (mod_env_q),
		.lo_i      (lo_i),
		.lo_q      (lo_q),
		.amp       (amp_d),
		.out_valid (valid),
		.out_i     (out_i),
		.out_q     (out_q)
	);

endmodule

`default_nettype wire

//--- logic/elem_sum.sv
// sums the four element streams into one I/Q stream; three cycles, wraps on overflow
`timescale 1ns/1ps
`default_nettype none

module elem_sum (
	input  logic              elem,
	input  logic              rst_n,
	input  logic              in_valid [elem_pkg::NELEM],
	input  elem_pkg::sample_t in_i [elem_pkg::NELEM],
	input  elem_pkg::sample_t in_q [elem_pkg::NELEM],
	output logic              out_valid,
	output elem_pkg::sample_t out_i,
	output elem_pkg::sample_t out_q
);
	import elem_pkg::*;

	sample_t mask_i [NELEM];
	sample_t mask_q [NELEM];
	sample_t pair_i [NELEM/2];
	sample_t pair_q [NELEM/2];
	sample_t tot_i;
	sample_t tot_q;
	logic any_valid;
	logic [2:0] valid_sr;

	// idle elements add zero
	always_comb begin
		any_valid = 1'b0;
		for (int k = 0; k < NELEM; k++) begin
			mask_i[k] = in_valid[k] ? in_i[k] : '0;
			mask_q[k] = in_valid[k] ? in_q[k] : '0;
			any_valid = any_valid | in_valid[k];
		end
	end

	always_ff @(posedge elem) begin
		for (int j = 0; j < NELEM/2; j++) begin
			pair_i[j] <= mask_i[2*j] + mask_i[2*j+1];
			pair_q[j] <= mask_q[2*j] + mask_q[2*j+1];
		end
		tot_i <= pair_i[0] + pair_i[1];
		tot_q <= pair_q[0] + pair_q[1];
		out_i <= tot_i;
		out_q <= tot_q;
	end

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n)
			valid_sr <= '0;
		else
			valid_sr <= {valid_sr[1:0], any_valid};
	end

	assign out_valid = valid_sr[2];

endmodule

`default_nettype wire

//--- logic/elem_top.sv
// drive waveform generator top level; host register and table ports in, summed I/Q stream out
`timescale 1ns/1ps
`default_nettype none

module elem_top #(
	parameter int TABLE_DEPTH = 1024
) (
	input  logic                elem,
	input  logic                rst_n,
	input  logic                wr_en,
	input  elem_pkg::reg_addr_t wr_addr,
	input  elem_pkg::reg_data_t wr_data,
	input  logic                tbl_wr_en,
	input  elem_pkg::tbl_sel_e  tbl_sel,
	input  elem_pkg::taddr_t    tbl_addr,
	input  logic [31:0]         tbl_data,  // {q, i}
	output logic                out_valid,
	output elem_pkg::sample_t   out_i,
	output elem_pkg::sample_t   out_q
);
	import elem_pkg::*;

	taddr_t env_addr [NELEM];
	taddr_t lo_addr [NELEM];
	sample_t env_i [NELEM];
	sample_t env_q [NELEM];
	sample_t lo_i [NELEM];
	sample_t lo_q [NELEM];
	logic e_valid [NELEM];
	sample_t e_i [NELEM];
	sample_t e_q [NELEM];

	wave_table #(.TABLE_DEPTH(TABLE_DEPTH)) env_tbl (
		.elem    (elem),
		.wr_en   (tbl_wr_en && (tbl_sel == ENV)),
		.wr_addr (tbl_addr),
		.wr_i    (tbl_data[15:0]),
		.wr_q    (tbl_data[31:16]),
		.rd_addr (env_addr),
		.rd_i    (env_i),
		.rd_q    (env_q)
	);

	wave_table #(.TABLE_DEPTH(TABLE_DEPTH)) lo_tbl (
		.elem    (elem),
		.wr_en   (tbl_wr_en && (tbl_sel == LO)),
		.wr_addr (tbl_addr),
		.wr_i    (tbl_data[15:0]),  // cos
		.wr_q    (tbl_data[31:16]), // sin
		.rd_addr (lo_addr),
		.rd_i    (lo_i),
		.rd_q    (lo_q)
	);

	for (genvar g = 0; g < NELEM; g++) begin : g_elem
		elem_cmd_if cmd_if ();

		elem_regs #(.ELEM_ID(g)) regs_i (
			.elem    (elem),
			.rst_n   (rst_n),
			.wr_en   (wr_en),
			.wr_addr (wr_addr),
			.wr_data (wr_data),
			.cmd     (cmd_if.cfg)
		);

		elem_conn #(.TABLE_DEPTH(TABLE_DEPTH)) conn_i (
			.elem     (elem),
			.rst_n    (rst_n),
			.cmd      (cmd_if.seq),
			.env_addr (env_addr[g]),
			.lo_addr  (lo_addr[g]),
			.env_i    (env_i[g]),
			.env_q    (env_q[g]),
			.lo_i     (lo_i[g]),
			.lo_q     (lo_q[g]),
			.valid    (e_valid[g]),
			.out_i    (e_i[g]),
			.out_q    (e_q[g])
		);
	end

	elem_sum sum_i (
		.elem      (elem),
		.rst_n     (rst_n),
		.in_valid  (e_valid),
		.in_i      (e_i),
		.in_q      (e_q),
		.out_valid (out_valid),
		.out_i     (out_i),
		.out_q     (out_q)
	);

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
// free-running testbench clock; PERIOD in ns, instantiated once by the testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic elem
);
	initial elem = 1'b0;

	always #(PERIOD / 2) elem = ~elem;

endmodule

`default_nettype wire

//--- verification/elem_tb.sv
// testbench for elem_top; loads random tables, runs pulses on the elements and checks the summed stream
`timescale 1ns/1ps
`default_nettype none

module elem_tb;
	import elem_pkg::*;

	localparam int LAT = 8;        // drive cycle of a write to the output cycle it affects
	localparam int CW_SPAN = 300;  // samples booked ahead for a cw pulse

	logic elem;
	logic rst_n;
	logic wr_en;
	reg_addr_t wr_addr;
	reg_data_t wr_data;
	logic tbl_wr_en;
	tbl_sel_e tbl_sel;
	taddr_t tbl_addr;
	logic [31:0] tbl_data;
	logic out_valid;
	sample_t out_i;
	sample_t out_q;

	logic [31:0] env_mem [1024];
	logic [31:0] lo_mem [1024];
	logic [31:0] exp_tab [int];  // {q, i} keyed by cycle*4 + element
	int fill_end [NELEM];
	int cfg_start [NELEM];
	int cfg_len [NELEM];
	int cfg_freq [NELEM];
	int cfg_amp [NELEM];
	int last_go [NELEM];
	int cyc = 0;
	logic [31:0] rng = 32'd2750;

	tb_clock #(.PERIOD(100)) clk_gen (.elem(elem));

	elem_top #(.TABLE_DEPTH(1024)) elem_top_i (
		.elem      (elem),
		.rst_n     (rst_n),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.tbl_wr_en (tbl_wr_en),
		.tbl_sel   (tbl_sel),
		.tbl_addr  (tbl_addr),
		.tbl_data  (tbl_data),
		.out_valid (out_valid),
		.out_i     (out_i),
		.out_q     (out_q)
	);

	always @(posedge elem) cyc <= cyc + 1;

	function automatic logic [15:0] rand16();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng[31:16];  // upper bits, the low ones repeat quickly
	endfunction

	// sample k of element e: envelope times carrier, then amplitude
	function automatic logic [31:0] ref_sample(int e, int k);
		taddr_t ea;
		taddr_t la;
		longint ex, ey, c, s;
		longint pi, pq, am;
		ea = taddr_t'(cfg_start[e] + k);  // both tables wrap at 1024
		la = taddr_t'(cfg_freq[e] + k);
		ex = (cfg_len[e] == 0) ? 32767 : longint'($signed(env_mem[ea][15:0]));
		ey = (cfg_len[e] == 0) ? 0 : longint'($signed(env_mem[ea][31:16]));
		c = longint'($signed(lo_mem[la][15:0]));
		s = longint'($signed(lo_mem[la][31:16]));
		pi = (ex * c - ey * s) >>> 15;
		pq = (ex * s + ey * c) >>> 15;
		pi = longint'($signed(pi[15:0]));
		pq = longint'($signed(pq[15:0]));
		am = cfg_amp[e];
		pi = (pi * am) >>> 15;
		pq = (pq * am) >>> 15;
		return {pq[15:0], pi[15:0]};
	endfunction

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_eq(string what, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic tick();
		@(posedge elem);
		#1;
	endtask

	task automatic idle(int n);
		repeat (n) tick();
	endtask

	task automatic reg_write(int e, reg_field_e f, logic [31:0] d);
		wr_en = 1'b1;
		wr_addr = {2'(e), 2'b00, 4'(f)};
		wr_data = d;
		tick();
		wr_en = 1'b0;
	endtask

	task automatic set_pulse(int e, int st, int ln, int fq, int am);
		cfg_start[e] = st;
		cfg_len[e] = ln;
		cfg_freq[e] = fq;
		cfg_amp[e] = am;
		reg_write(e, ENVSTART, st);
		reg_write(e, ENVLEN, ln);
		reg_write(e, FREQADDR, fq);
		reg_write(e, AMP, am);
	endtask

	task automatic random_pulse(int e, int min_len);
		int st, ln, fq, am;
		st = rand16() % 1024;
		ln = min_len + rand16() % 32;
		fq = rand16() % 1024;
		am = rand16();
		set_pulse(e, st, ln, fq, am);
	endtask

	// drop what element e would still emit from cycle c0 on
	task automatic trim(int e, int c0);
		for (int c = c0; c < fill_end[e]; c++)
			if (exp_tab.exists(c * 4 + e))
				exp_tab.delete(c * 4 + e);
		if (fill_end[e] > c0)
			fill_end[e] = c0;
	endtask

	task automatic go(int e);
		int n;
		last_go[e] = cyc;
		reg_write(e, GO, 32'd0);
		trim(e, last_go[e] + LAT);  // a restart replaces the old stream
		n = (cfg_len[e] == 0) ? CW_SPAN : cfg_len[e];
		for (int k = 0; k < n; k++)
			exp_tab[(last_go[e] + LAT + k) * 4 + e] = ref_sample(e, k);
		fill_end[e] = last_go[e] + LAT + n;
	endtask

	task automatic stop(int e);
		int p;
		p = cyc;
		reg_write(e, STOP, 32'd0);
		trim(e, p + LAT);
	endtask

	task automatic drain(int limit);
		int n;
		int last;
		n = 0;
		last = 0;
		for (int e = 0; e < NELEM; e++)
			if (fill_end[e] > last)
				last = fill_end[e];
		while ((out_valid || cyc <= last) && n < limit) begin
			tick();
			n++;
		end
		if (out_valid || cyc <= last) begin
			$display("timed out waiting for the output stream to end");
			abort_run();
		end
	endtask

	task automatic load_tables();
		logic [31:0] v;
		tbl_wr_en = 1'b1;
		for (int s = 0; s < 2; s++) begin
			tbl_sel = (s == 0) ? ENV : LO;
			for (int a = 0; a < 1024; a++) begin
				v[15:0] = rand16();
				v[31:16] = rand16();
				tbl_addr = taddr_t'(a);
				tbl_data = v;
				if (s == 0)
					env_mem[a] = v;
				else
					lo_mem[a] = v;
				tick();
			end
		end
		tbl_wr_en = 1'b0;
	endtask

	// every cycle, sum what the active elements should give
	always @(negedge elem) begin : collect
		logic [31:0] d;
		logic [15:0] si;
		logic [15:0] sq;
		logic ev;
		if (rst_n) begin
			si = '0;
			sq = '0;
			ev = 1'b0;
			for (int e = 0; e < NELEM; e++) begin
				if (exp_tab.exists(cyc * 4 + e)) begin
					d = exp_tab[cyc * 4 + e];
					si = si + d[15:0];  // wraps like the adder tree
					sq = sq + d[31:16];
					ev = 1'b1;
				end
			end
			check_eq("out_valid", out_valid, ev);
			if (ev) begin
				check_eq("out_i", unsigned'(out_i), si);
				check_eq("out_q", unsigned'(out_q), sq);
			end
		end
	end

	initial begin
		int n;
		rst_n = 1'b0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		tbl_wr_en = 1'b0;
		tbl_sel = ENV;
		tbl_addr = '0;
		tbl_data = '0;
		repeat (10) @(posedge elem);
		#1 rst_n = 1'b1;
		idle(20);  // quiet output after reset
		load_tables();

		// single pulse, latency and run length
		random_pulse(0, 1);
		go(0);
		n = 0;
		while (!out_valid && n < 20) begin
			tick();
			n++;
		end
		if (!out_valid) begin
			$display("timed out waiting for the first valid sample");
			abort_run();
		end
		check_eq("first valid latency", cyc - last_go[0], LAT);
		n = 0;
		while (out_valid && n <= cfg_len[0]) begin
			n++;
			tick();
		end
		check_eq("valid run length", n, cfg_len[0]);
		drain(200);

		// one host port, so the four gos go out back to back
		for (int e = 0; e < NELEM; e++)
			random_pulse(e, 16);
		for (int e = 0; e < NELEM; e++)
			go(e);
		drain(300);

		// staggered and overlapping
		set_pulse(0, 100, 40, 7, 32768);
		set_pulse(1, 1000, 15, 1020, 20000);
		set_pulse(2, 500, 60, 300, 65535);
		set_pulse(3, 20, 30, 900, 12345);
		go(0);
		idle(10);
		go(1);
		idle(5);
		go(2);
		idle(20);
		go(3);
		drain(400);

		// continuous wave until stop
		set_pulse(1, 0, 0, 1000, 40000);
		go(1);
		idle(50);
		stop(1);
		drain(100);
		idle(40);

		// restart in the middle of a pulse
		set_pulse(2, 200, 50, 50, 30000);
		go(2);
		idle(12);
		set_pulse(2, 700, 20, 600, 50000);
		go(2);
		drain(200);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
logic/elem_pkg.sv
logic/elem_cmd_if.sv
logic/am_mod.sv
logic/wave_table.sv
logic/elem_regs.sv
logic/elem_conn.sv
logic/elem_sum.sv
logic/elem_top.sv
verification/tb_clock.sv
verification/elem_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module elem_tb -f src.f -o elem_sim

out=$(./obj_dir/elem_sim) || true
echo "$out"
grep -q "Simulation completed successfully" <<< "$out"
